// File: logic/llc_macros.svh
`ifndef LLC_MACROS_SVH
`define LLC_MACROS_SVH

// ************************************************
// Cache geometry.
// ************************************************

// Associativity and set count.
`define LLC_WAYS 4
`define LLC_SETS 16

// Index widths, log2 of the counts above.
`define LLC_SET_BITS 4
`define LLC_WAY_BITS 2

// ************************************************
// Address split.
// ************************************************

// A line address is the tag followed by the set index.
`define LLC_TAG_BITS 12
`define LLC_LINE_ADDR_BITS 16

`endif

// File: logic/llc_types_pkg.sv
`include "llc_macros.svh"

package llc_types_pkg;

    // Address fields.
    typedef logic [`LLC_SET_BITS-1:0] llc_set_t;
    typedef logic [`LLC_TAG_BITS-1:0] llc_tag_t;
    typedef logic [`LLC_WAY_BITS-1:0] llc_way_t;

    // Tag in the upper bits, set in the lower bits.
    typedef logic [`LLC_LINE_ADDR_BITS-1:0] line_addr_t;

    // Request from the client.
    typedef struct packed {
        line_addr_t addr;
        logic       is_write;
    } llc_req_t;

    // Lookup result, with the victim line on a miss.
    typedef struct packed {
        logic       hit;
        llc_way_t   way;
        logic       evict_valid;
        logic       evict_dirty;
        line_addr_t evict_addr;
    } llc_rsp_t;

endpackage

// File: logic/llc_ctrl_pkg.sv
package llc_ctrl_pkg;

    // Controller states.
    typedef enum logic [2:0] {
        RST_SWEEP,
        IDLE,
        FLUSH_SWEEP,
        DECODE,
        RD_SET,
        LOOKUP,
        UPDATE
    } llc_state_t;

    // Strobes from the FSM to the register block.
    typedef struct packed {
        logic clr_rst_stall;
        logic set_flush_stall;
        logic clr_flush_stall;
        logic clr_sweep_set;
        logic incr_sweep_set;
        logic set_req_in_stalled_valid;
        logic clr_req_in_stalled_valid;
        logic update_req_in_stalled;
        logic set_update_evict_way;
        logic decode_en;
        logic lookup_en;
    } llc_reg_ctrl_t;

endpackage

// File: logic/llc_regs.sv
`include "llc_macros.svh"

module llc_regs (
    input  logic                          clk,
    input  logic                          rst,
    input  llc_ctrl_pkg::llc_reg_ctrl_t   reg_ctrl,
    input  llc_types_pkg::llc_req_t       req,
    input  llc_types_pkg::llc_tag_t       tags_buf [`LLC_WAYS],
    input  llc_types_pkg::llc_way_t       way_next,
    input  llc_types_pkg::llc_set_t       set,
    output logic                          rst_stall,
    output logic                          flush_stall,
    output logic                          req_in_stalled_valid,
    output llc_types_pkg::llc_req_t       req_in_stalled,
    output llc_types_pkg::llc_set_t       sweep_set,
    output logic                          update_evict_way,
    output llc_types_pkg::line_addr_t     addr_evict
);

    // **************************************************
    // Status flags.
    // **************************************************

    // Set by reset, cleared once the reset sweep is done.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rst_stall <= 1'b1;
        end else if (reg_ctrl.clr_rst_stall) begin
            rst_stall <= 1'b0;
        end
    end

    // Clear has priority over set.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            flush_stall <= 1'b0;
        end else if (reg_ctrl.clr_flush_stall) begin
            flush_stall <= 1'b0;
        end else if (reg_ctrl.set_flush_stall) begin
            flush_stall <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_in_stalled_valid <= 1'b0;
        end else if (reg_ctrl.clr_req_in_stalled_valid) begin
            req_in_stalled_valid <= 1'b0;
        end else if (reg_ctrl.set_req_in_stalled_valid) begin
            req_in_stalled_valid <= 1'b1;
        end
    end

    // Marks a miss; each new request starts clean in decode.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            update_evict_way <= 1'b0;
        end else if (reg_ctrl.decode_en) begin
            update_evict_way <= 1'b0;
        end else if (reg_ctrl.set_update_evict_way) begin
            update_evict_way <= 1'b1;
        end
    end

    // **************************************************
    // Sweep counter, shared by reset and flush.
    // **************************************************

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sweep_set <= '0;
        end else if (reg_ctrl.clr_sweep_set) begin
            sweep_set <= '0;
        end else if (reg_ctrl.incr_sweep_set) begin
            sweep_set <= sweep_set + 1'b1;
        end
    end

    // **************************************************
    // Request and eviction address.
    // **************************************************

    // Holds the request in service, or the one parked during a flush.
    always_ff @(posedge clk) begin
        if (reg_ctrl.update_req_in_stalled) begin
            req_in_stalled <= req;
        end
    end

    // Victim tag joined with the set.
    always_ff @(posedge clk) begin
        if (reg_ctrl.lookup_en) begin
            addr_evict <= {tags_buf[way_next], set};
        end
    end

endmodule

// File: logic/llc_tag_store.sv
`include "llc_macros.svh"

module llc_tag_store (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rd_set_en,
    input  llc_types_pkg::llc_set_t   rd_set,
    input  logic                      wr_en,
    input  llc_types_pkg::llc_way_t   wr_way,
    input  llc_types_pkg::llc_tag_t   wr_tag,
    input  logic                      wr_dirty,
    input  logic                      advance_ptr,
    input  logic                      sweep_en,
    input  llc_types_pkg::llc_set_t   sweep_set,
    output llc_types_pkg::llc_tag_t   tags_buf [`LLC_WAYS],
    output logic [`LLC_WAYS-1:0]      valid_buf,
    output logic [`LLC_WAYS-1:0]      dirty_buf,
    output llc_types_pkg::llc_way_t   evict_ptr
);
    import llc_types_pkg::*;

    llc_tag_t                             tags [`LLC_SETS][`LLC_WAYS];
    logic [`LLC_SETS-1:0][`LLC_WAYS-1:0]     valid;
    logic [`LLC_SETS-1:0][`LLC_WAYS-1:0]     dirty;
    logic [`LLC_SETS-1:0][`LLC_WAY_BITS-1:0] ptr;

    // Tag array.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tags[rd_set][wr_way] <= wr_tag;
        end
    end

    // State bits and replacement pointer; a sweep clears one set per cycle.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid <= '0;
            dirty <= '0;
            ptr   <= '0;
        end else if (sweep_en) begin
            valid[sweep_set] <= '0;
            dirty[sweep_set] <= '0;
            ptr[sweep_set]   <= '0;
        end else begin
            if (wr_en) begin
                valid[rd_set][wr_way] <= 1'b1;
                dirty[rd_set][wr_way] <= wr_dirty;
            end
            // Round robin, wraps modulo the way count.
            if (advance_ptr) begin
                ptr[rd_set] <= ptr[rd_set] + 1'b1;
            end
        end
    end

    // Whole set read into the buffers.
    always_ff @(posedge clk) begin
        if (rd_set_en) begin
            for (int w = 0; w < `LLC_WAYS; w++) begin
                tags_buf[w] <= tags[rd_set][w];
            end
            valid_buf <= valid[rd_set];
            dirty_buf <= dirty[rd_set];
            evict_ptr <= ptr[rd_set];
        end
    end

endmodule

// File: logic/llc_ctrl_fsm.sv
`include "llc_macros.svh"

module llc_ctrl_fsm (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    input  llc_types_pkg::llc_req_t       req,
    input  logic                          flush,
    input  logic                          rst_stall,
    input  logic                          flush_stall,
    input  logic                          req_in_stalled_valid,
    input  llc_types_pkg::llc_req_t       req_in_stalled,
    input  llc_types_pkg::llc_set_t       sweep_set,
    input  logic                          update_evict_way,
    input  llc_types_pkg::llc_tag_t       tags_buf [`LLC_WAYS],
    input  logic [`LLC_WAYS-1:0]          valid_buf,
    input  logic [`LLC_WAYS-1:0]          dirty_buf,
    input  llc_types_pkg::llc_way_t       evict_ptr,
    input  llc_types_pkg::line_addr_t     addr_evict,
    output llc_ctrl_pkg::llc_reg_ctrl_t   reg_ctrl,
    output logic                          ready,
    output logic                          rd_set_en,
    output llc_types_pkg::llc_set_t       rd_set,
    output logic                          wr_en,
    output llc_types_pkg::llc_way_t       wr_way,
    output llc_types_pkg::llc_tag_t       wr_tag,
    output logic                          wr_dirty,
    output logic                          advance_ptr,
    output logic                          sweep_en,
    output llc_types_pkg::llc_way_t       way_next,
    output logic                          rsp_valid,
    output llc_types_pkg::llc_rsp_t       rsp,
    output logic                          flush_done
);
    import llc_types_pkg::*;
    import llc_ctrl_pkg::*;

    llc_state_t           state;
    llc_state_t           state_next;
    llc_tag_t             req_tag;
    logic [`LLC_WAYS-1:0] hit_vec;
    logic                 hit;
    llc_way_t             hit_way;
    logic                 last_set;
    logic                 evict_valid;

    assign req_tag  = req_in_stalled.addr[`LLC_LINE_ADDR_BITS-1:`LLC_SET_BITS];
    assign rd_set   = req_in_stalled.addr[`LLC_SET_BITS-1:0];
    assign last_set = (sweep_set == llc_set_t'(`LLC_SETS - 1));

    // **************************************************
    // Tag compare and way choice.
    // **************************************************

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `LLC_WAYS; w++) begin
            hit_vec[w] = valid_buf[w] && (tags_buf[w] == req_tag);
            if (hit_vec[w]) begin
                hit_way = llc_way_t'(w);
            end
        end
    end

    assign hit      = |hit_vec;
    assign way_next = hit ? hit_way : evict_ptr;

    // Fill or dirty update; a hit keeps its dirty bit.
    assign wr_way   = way_next;
    assign wr_tag   = req_tag;
    assign wr_dirty = req_in_stalled.is_write || (hit && dirty_buf[way_next]);

    // Response, meaningful in UPDATE.
    assign evict_valid = update_evict_way && valid_buf[evict_ptr];

    always_comb begin
        rsp.hit         = !update_evict_way;
        rsp.way         = way_next;
        rsp.evict_valid = evict_valid;
        rsp.evict_dirty = evict_valid && dirty_buf[evict_ptr];
        rsp.evict_addr  = evict_valid ? addr_evict : '0;
    end

    // **************************************************
    // State machine.
    // **************************************************

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= RST_SWEEP;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next  = state;
        reg_ctrl    = '0;
        ready       = 1'b0;
        rd_set_en   = 1'b0;
        wr_en       = 1'b0;
        advance_ptr = 1'b0;
        sweep_en    = 1'b0;
        rsp_valid   = 1'b0;
        flush_done  = 1'b0;
        case (state)
            RST_SWEEP: begin
                // One extra cycle after the last set, once rst_stall drops.
                if (rst_stall) begin
                    sweep_en                = 1'b1;
                    reg_ctrl.incr_sweep_set = 1'b1;
                    reg_ctrl.clr_rst_stall  = last_set;
                end else begin
                    state_next = IDLE;
                end
            end
            IDLE: begin
                ready = 1'b1;
                if (flush) begin
                    reg_ctrl.set_flush_stall          = 1'b1;
                    reg_ctrl.clr_sweep_set            = 1'b1;
                    reg_ctrl.set_req_in_stalled_valid = req_valid;
                    reg_ctrl.update_req_in_stalled    = req_valid;
                    state_next                        = FLUSH_SWEEP;
                end else if (req_valid) begin
                    reg_ctrl.update_req_in_stalled = 1'b1;
                    state_next                     = DECODE;
                end
            end
            FLUSH_SWEEP: begin
                if (flush_stall) begin
                    ready                     = !req_in_stalled_valid;
                    sweep_en                  = 1'b1;
                    reg_ctrl.incr_sweep_set   = 1'b1;
                    reg_ctrl.clr_flush_stall  = last_set;
                    // Park at most one request.
                    if (req_valid && !req_in_stalled_valid) begin
                        reg_ctrl.set_req_in_stalled_valid = 1'b1;
                        reg_ctrl.update_req_in_stalled    = 1'b1;
                    end
                end else begin
                    flush_done                        = 1'b1;
                    reg_ctrl.clr_req_in_stalled_valid = 1'b1;
                    state_next = req_in_stalled_valid ? DECODE : IDLE;
                end
            end
            DECODE: begin
                reg_ctrl.decode_en = 1'b1;
                state_next         = RD_SET;
            end
            RD_SET: begin
                rd_set_en  = 1'b1;
                state_next = LOOKUP;
            end
            LOOKUP: begin
                reg_ctrl.lookup_en            = 1'b1;
                reg_ctrl.set_update_evict_way = !hit;
                state_next                    = UPDATE;
            end
            UPDATE: begin
                wr_en       = 1'b1;
                advance_ptr = update_evict_way;
                rsp_valid   = 1'b1;
                state_next  = IDLE;
            end
            default: begin
                state_next = RST_SWEEP;
            end
        endcase
    end

endmodule

// File: logic/llc_ctrl_top.sv
`include "llc_macros.svh"

module llc_ctrl_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    input  llc_types_pkg::llc_req_t   req,
    input  logic                      flush,
    output logic                      ready,
    output logic                      rsp_valid,
    output llc_types_pkg::llc_rsp_t   rsp,
    output logic                      flush_done
);
    import llc_types_pkg::*;
    import llc_ctrl_pkg::*;

    // FSM to registers.
    llc_reg_ctrl_t reg_ctrl;
    llc_way_t      way_next;

    // Registers back to the FSM.
    logic          rst_stall;
    logic          flush_stall;
    logic          req_in_stalled_valid;
    logic          update_evict_way;
    llc_req_t      req_in_stalled;
    llc_set_t      sweep_set;
    line_addr_t    addr_evict;

    // Tag store traffic.
    llc_tag_t             tags_buf [`LLC_WAYS];
    logic [`LLC_WAYS-1:0] valid_buf;
    logic [`LLC_WAYS-1:0] dirty_buf;
    llc_way_t             evict_ptr;
    logic                 rd_set_en;
    llc_set_t             rd_set;
    logic                 wr_en;
    llc_way_t             wr_way;
    llc_tag_t             wr_tag;
    logic                 wr_dirty;
    logic                 advance_ptr;
    logic                 sweep_en;

    llc_ctrl_fsm llc_ctrl_fsm_inst (
        .clk                  (clk),
        .rst                  (rst),
        .req_valid            (req_valid),
        .req                  (req),
        .flush                (flush),
        .rst_stall            (rst_stall),
        .flush_stall          (flush_stall),
        .req_in_stalled_valid (req_in_stalled_valid),
        .req_in_stalled       (req_in_stalled),
        .sweep_set            (sweep_set),
        .update_evict_way     (update_evict_way),
        .tags_buf             (tags_buf),
        .valid_buf            (valid_buf),
        .dirty_buf            (dirty_buf),
        .evict_ptr            (evict_ptr),
        .addr_evict           (addr_evict),
        .reg_ctrl             (reg_ctrl),
        .ready                (ready),
        .rd_set_en            (rd_set_en),
        .rd_set               (rd_set),
        .wr_en                (wr_en),
        .wr_way               (wr_way),
        .wr_tag               (wr_tag),
        .wr_dirty             (wr_dirty),
        .advance_ptr          (advance_ptr),
        .sweep_en             (sweep_en),
        .way_next             (way_next),
        .rsp_valid            (rsp_valid),
        .rsp                  (rsp),
        .flush_done           (flush_done)
    );

    llc_regs llc_regs_inst (
        .clk                  (clk),
        .rst                  (rst),
        .reg_ctrl             (reg_ctrl),
        .req                  (req),
        .tags_buf             (tags_buf),
        .way_next             (way_next),
        .set                  (rd_set),
        .rst_stall            (rst_stall),
        .flush_stall          (flush_stall),
        .req_in_stalled_valid (req_in_stalled_valid),
        .req_in_stalled       (req_in_stalled),
        .sweep_set            (sweep_set),
        .update_evict_way     (update_evict_way),
        .addr_evict           (addr_evict)
    );

    llc_tag_store llc_tag_store_inst (
        .clk         (clk),
        .rst         (rst),
        .rd_set_en   (rd_set_en),
        .rd_set      (rd_set),
        .wr_en       (wr_en),
        .wr_way      (wr_way),
        .wr_tag      (wr_tag),
        .wr_dirty    (wr_dirty),
        .advance_ptr (advance_ptr),
        .sweep_en    (sweep_en),
        .sweep_set   (sweep_set),
        .tags_buf    (tags_buf),
        .valid_buf   (valid_buf),
        .dirty_buf   (dirty_buf),
        .evict_ptr   (evict_ptr)
    );

endmodule

// File: tb/llc_ctrl_tb.sv
`include "llc_macros.svh"

module llc_ctrl_tb;
    import llc_types_pkg::*;

    localparam int NUM_RANDOM   = 400;
    localparam int NUM_DIRECTED = 40;
    // Reset and flushes need about 100 cycles, and each request needs 5.
    localparam int CYCLE_LIMIT  = 200 + (NUM_RANDOM + NUM_DIRECTED) * 8;

    logic     clk;
    logic     rst;
    logic     req_valid;
    llc_req_t req;
    logic     flush;
    logic     ready;
    logic     rsp_valid;
    llc_rsp_t rsp;
    logic     flush_done;

    // Reference model of the tag array.
    llc_tag_t             m_tag   [`LLC_SETS][`LLC_WAYS];
    logic [`LLC_WAYS-1:0] m_valid [`LLC_SETS];
    logic [`LLC_WAYS-1:0] m_dirty [`LLC_SETS];
    llc_way_t             m_ptr   [`LLC_SETS];

    llc_rsp_t exp_q       [$];
    int       exp_cycle_q [$];

    integer seed;
    int     cycle;
    int     checks;
    int     errors;
    int     flush_seen;
    int     flush_count;
    int     flush_done_cycle;

    llc_ctrl_top llc_ctrl_top_inst (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .flush      (flush),
        .ready      (ready),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .flush_done (flush_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // **************************************************
    // Reference model.
    // **************************************************

    function automatic void model_flush();
        for (int s = 0; s < `LLC_SETS; s++) begin
            m_valid[s] = '0;
            m_dirty[s] = '0;
            m_ptr[s]   = '0;
        end
    endfunction

    function automatic llc_rsp_t model_access(input line_addr_t addr, input logic is_write);
        llc_set_t s;
        llc_tag_t t;
        llc_way_t v;
        llc_rsp_t r;
        s = addr[`LLC_SET_BITS-1:0];
        t = addr[`LLC_LINE_ADDR_BITS-1:`LLC_SET_BITS];
        r = '0;
        for (int w = 0; w < `LLC_WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == t) begin
                r.hit = 1'b1;
                r.way = llc_way_t'(w);
            end
        end
        if (r.hit) begin
            if (is_write) begin
                m_dirty[s][r.way] = 1'b1;
            end
        end else begin
            // Victim at the round robin pointer.
            v             = m_ptr[s];
            r.way         = v;
            r.evict_valid = m_valid[s][v];
            r.evict_dirty = m_valid[s][v] && m_dirty[s][v];
            if (r.evict_valid) begin
                r.evict_addr = {m_tag[s][v], s};
            end
            m_tag[s][v]   = t;
            m_valid[s][v] = 1'b1;
            m_dirty[s][v] = is_write;
            m_ptr[s]      = v + 1'b1;
        end
        return r;
    endfunction

    // **************************************************
    // Checker.
    // **************************************************

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error: %s = 0x%h, expected 0x%h at cycle %0d", name, got, exp, cycle);
            errors++;
        end
    endtask

    // Sampled at the falling edge, inside the UPDATE cycle.
    always @(negedge clk) begin : compare_rsp
        llc_rsp_t exp_rsp;
        int       exp_cycle;
        if (rst && rsp_valid) begin
            checks++;
            assert (exp_q.size() > 0) else begin
                $display("Error: response at cycle %0d with no request pending", cycle);
                errors++;
            end
            if (exp_q.size() > 0) begin
                exp_rsp   = exp_q.pop_front();
                exp_cycle = exp_cycle_q.pop_front();
                check_value("rsp.hit", 16'(rsp.hit), 16'(exp_rsp.hit));
                check_value("rsp.way", 16'(rsp.way), 16'(exp_rsp.way));
                check_value("rsp.evict_valid", 16'(rsp.evict_valid), 16'(exp_rsp.evict_valid));
                check_value("rsp.evict_dirty", 16'(rsp.evict_dirty), 16'(exp_rsp.evict_dirty));
                check_value("rsp.evict_addr", rsp.evict_addr, exp_rsp.evict_addr);
                checks++;
                assert (cycle == exp_cycle) else begin
                    $display("Error: response came at cycle %0d instead of cycle %0d",
                             cycle, exp_cycle);
                    errors++;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (rst && flush_done) begin
            flush_seen++;
            flush_done_cycle = cycle;
        end
    end

    // **************************************************
    // Stimulus.
    // **************************************************

    // Lead is the number of cycles from the accepting edge to the response.
    task automatic issue_req(input line_addr_t addr, input logic is_write, input int lead);
        llc_rsp_t exp_rsp;
        while (ready !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        exp_rsp      = model_access(addr, is_write);
        req_valid    = 1'b1;
        req.addr     = addr;
        req.is_write = is_write;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        exp_q.push_back(exp_rsp);
        exp_cycle_q.push_back(cycle + lead);
        check_value("ready", 16'(ready), 16'h0);
    endtask

    task automatic drain_responses();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic do_flush(input logic with_req, input line_addr_t addr, input logic is_write);
        int start;
        int seen;
        drain_responses();
        while (ready !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        model_flush();
        seen  = flush_seen;
        flush = 1'b1;
        flush_count++;
        @(posedge clk);
        #1;
        flush = 1'b0;
        start = cycle;
        if (with_req) begin
            repeat (3) begin
                @(posedge clk);
                #1;
            end
            // Captured 4 cycles into the sweep, answered 4 cycles after flush_done.
            issue_req(addr, is_write, 16);
        end
        while (flush_seen == seen) begin
            @(posedge clk);
            #1;
        end
        checks++;
        assert (flush_done_cycle == start + 16) else begin
            $display("Error: flush_done came at cycle %0d instead of cycle %0d",
                     flush_done_cycle, start + 16);
            errors++;
        end
    endtask

    initial begin
        logic [31:0] rnd;
        int          rel;
        seed        = 32'h9547;
        cycle       = 0;
        checks      = 0;
        errors      = 0;
        flush_seen  = 0;
        flush_count = 0;
        rst         = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        flush       = 1'b0;
        model_flush();

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b1;
        rel = cycle;
        check_value("ready", 16'(ready), 16'h0);
        check_value("rsp_valid", 16'(rsp_valid), 16'h0);
        check_value("flush_done", 16'(flush_done), 16'h0);
        while (ready !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        checks++;
        assert (cycle - rel == 17) else begin
            $display("Error: ready rose %0d cycles after reset release, expected 17",
                     cycle - rel);
            errors++;
        end

        // First accesses miss, repeats hit, a write hit marks the line dirty.
        issue_req(16'h0123, 1'b0, 3);
        issue_req(16'h0123, 1'b0, 3);
        issue_req(16'h0123, 1'b1, 3);
        issue_req(16'h0456, 1'b1, 3);
        issue_req(16'h0456, 1'b0, 3);

        // Four more tags in set 3 push out the line written above.
        for (int t = 1; t <= 4; t++) begin
            issue_req({12'(t), 4'h3}, 1'b0, 3);
        end

        // Six tags in set 5; the first one is dirty when evicted.
        for (int t = 1; t <= 6; t++) begin
            issue_req({12'(t), 4'h5}, t == 1, 3);
        end

        // Everything misses after a flush.
        do_flush(1'b0, '0, 1'b0);
        issue_req(16'h0123, 1'b0, 3);
        issue_req(16'h0456, 1'b0, 3);
        for (int t = 3; t <= 6; t++) begin
            issue_req({12'(t), 4'h5}, 1'b0, 3);
        end

        // One request parked during a flush.
        do_flush(1'b1, 16'h0789, 1'b1);
        drain_responses();
        issue_req(16'h0789, 1'b0, 3);

        // Few tags over few sets, so hits and evictions both occur.
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd = $random(seed);
            issue_req({9'd0, rnd[6:4], 2'd0, rnd[1:0]}, rnd[8], 3);
        end
        drain_responses();

        // One single-cycle flush_done for each flush.
        checks++;
        assert (flush_seen == flush_count) else begin
            $display("Error: flush_done was high in %0d cycles for %0d flushes",
                     flush_seen, flush_count);
            errors++;
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+logic
logic/llc_types_pkg.sv
logic/llc_ctrl_pkg.sv
logic/llc_regs.sv
logic/llc_tag_store.sv
logic/llc_ctrl_fsm.sv
logic/llc_ctrl_top.sv
tb/llc_ctrl_tb.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= llc_ctrl_tb
RTL_TOP   ?= llc_ctrl_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
